// File: lsu_mem_pkg.sv
// Shared sizes, opcode enum and opcode helpers for the load/store data memory
`default_nettype none

package lsu_mem_pkg;

  // Bus and memory geometry
  localparam int BYTE_SIZE = 8;
  localparam int DATA_SIZE = 32;
  localparam int LANES = DATA_SIZE / BYTE_SIZE;
  localparam int ADDR_SIZE = 6;

  // Edges from the RAM taking a strobe to its acknowledge
  localparam int BUSY_CYCLES = 3;

  typedef logic [ADDR_SIZE-1:0] mem_addr_t;
  typedef logic [$clog2(BUSY_CYCLES)-1:0] busy_cnt_t;

  // Loads first, then stores
  typedef enum logic [2:0] {
    OP_LB,
    OP_LH,
    OP_LW,
    OP_LBU,
    OP_LHU,
    OP_SB,
    OP_SH,
    OP_SW
  } mem_op_e;

  function automatic logic is_store(mem_op_e op);
    return op inside {OP_SB, OP_SH, OP_SW};
  endfunction

  // Byte selects always start at lane 0
  function automatic logic [LANES-1:0] op_sel(mem_op_e op);
    logic [LANES-1:0] sel;
    case (op)
      OP_LB, OP_LBU, OP_SB: sel = LANES'(1);
      OP_LH, OP_LHU, OP_SH: sel = LANES'(3);
      default:              sel = '1;
    endcase
    return sel;
  endfunction

endpackage

`default_nettype wire

// File: wb_if.sv
// Wishbone-style bus between the request stage (master) and the byte-lane RAM (slave)
`default_nettype none

interface wb_if;

  logic [lsu_mem_pkg::DATA_SIZE-1:0] adr;
  logic [lsu_mem_pkg::DATA_SIZE-1:0] dat_w;
  logic [lsu_mem_pkg::DATA_SIZE-1:0] dat_r;
  logic                              cyc;
  logic                              stb;
  logic                              we;
  logic [lsu_mem_pkg::LANES-1:0]     sel;
  logic                              ack;

  modport master (
    output adr, dat_w, cyc, stb, we, sel,
    input  dat_r, ack
  );

  modport slave (
    input  adr, dat_w, cyc, stb, we, sel,
    output dat_r, ack
  );

endinterface

`default_nettype wire

// File: mem_request.sv
// Request stage that takes one command and holds a bus cycle on it until acknowledge
`default_nettype none

module mem_request (
  input  logic                              CLK_I,
  input  logic                              arst_n,
  input  logic                              cmd_valid,
  input  lsu_mem_pkg::mem_op_e              cmd_op,
  input  logic [lsu_mem_pkg::DATA_SIZE-1:0] cmd_addr,
  input  logic [lsu_mem_pkg::DATA_SIZE-1:0] cmd_wdata,
  output logic                              cmd_ready,
  output lsu_mem_pkg::mem_op_e              op_q,
  wb_if.master                              bus
);

  typedef enum logic {
    ST_IDLE,
    ST_BUS
  } state_e;

  state_e state;

  logic [lsu_mem_pkg::DATA_SIZE-1:0] adr_q;
  logic [lsu_mem_pkg::DATA_SIZE-1:0] wdata_q;
  logic                              accept;

  assign accept = cmd_valid && cmd_ready;

  // Idle means ready; a strobe seen while busy is simply dropped
  assign cmd_ready = (state == ST_IDLE);

  always_ff @(posedge CLK_I or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state <= ST_BUS;
          end
        end
        ST_BUS: begin
          // Cycle ends on the edge that samples ack
          if (bus.ack) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Command payload held stable for the whole bus cycle
  always_ff @(posedge CLK_I) begin
    if (accept) begin
      op_q    <= cmd_op;
      adr_q   <= cmd_addr;
      wdata_q <= cmd_wdata;
    end
  end

  assign bus.cyc   = (state == ST_BUS);
  assign bus.stb   = (state == ST_BUS);
  assign bus.adr   = adr_q;
  assign bus.dat_w = wdata_q;
  assign bus.we    = lsu_mem_pkg::is_store(op_q);
  // Byte, half or word in the low lanes
  assign bus.sel   = lsu_mem_pkg::op_sel(op_q);

endmodule

`default_nettype wire

// File: wb_byte_ram.sv
// Byte-lane single-port RAM slave with read-before-write and a delayed one-cycle ack
`default_nettype none

module wb_byte_ram (
  input  logic CLK_I,
  input  logic arst_n,
  wb_if.slave  bus
);

  logic [lsu_mem_pkg::BYTE_SIZE-1:0] mem [2**lsu_mem_pkg::ADDR_SIZE];

  lsu_mem_pkg::mem_addr_t lane_adr [lsu_mem_pkg::LANES];
  lsu_mem_pkg::busy_cnt_t busy_cnt;
  logic                   start;

  // Lane i hits byte adr + i, wrapping at the top of memory
  always_comb begin
    for (int i = 0; i < lsu_mem_pkg::LANES; i++) begin
      lane_adr[i] = bus.adr[lsu_mem_pkg::ADDR_SIZE-1:0] + lsu_mem_pkg::mem_addr_t'(i);
    end
  end

  // Only a fresh strobe starts an access, never one seen during ack or countdown
  assign start = bus.cyc && bus.stb && !bus.ack && (busy_cnt == '0);

  // Old bytes are captured before the write lands, so a store returns what it replaced
  always_ff @(posedge CLK_I) begin
    if (start) begin
      for (int i = 0; i < lsu_mem_pkg::LANES; i++) begin
        if (bus.sel[i]) begin
          bus.dat_r[i*lsu_mem_pkg::BYTE_SIZE +: lsu_mem_pkg::BYTE_SIZE] <= mem[lane_adr[i]];
          if (bus.we) begin
            mem[lane_adr[i]] <= bus.dat_w[i*lsu_mem_pkg::BYTE_SIZE +: lsu_mem_pkg::BYTE_SIZE];
          end
        end else begin
          bus.dat_r[i*lsu_mem_pkg::BYTE_SIZE +: lsu_mem_pkg::BYTE_SIZE] <= '0;
        end
      end
    end
  end

  // Countdown from the start edge; ack rises on the last count and lasts one cycle
  always_ff @(posedge CLK_I or negedge arst_n) begin
    if (!arst_n) begin
      busy_cnt <= '0;
      bus.ack  <= 1'b0;
    end else begin
      bus.ack <= 1'b0;
      if (busy_cnt == lsu_mem_pkg::busy_cnt_t'(lsu_mem_pkg::BUSY_CYCLES - 1)) begin
        bus.ack  <= 1'b1;
        busy_cnt <= '0;
      end else if (busy_cnt != '0) begin
        busy_cnt <= busy_cnt + 1'b1;
      end else if (start) begin
        busy_cnt <= lsu_mem_pkg::busy_cnt_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

// File: load_extend.sv
// Response stage that extends returned data by opcode and pulses the response
`default_nettype none

module load_extend (
  input  logic                              CLK_I,
  input  logic                              arst_n,
  input  logic                              ack,
  input  logic [lsu_mem_pkg::DATA_SIZE-1:0] dat_r,
  input  lsu_mem_pkg::mem_op_e              op,
  output logic                              rsp_valid,
  output logic [lsu_mem_pkg::DATA_SIZE-1:0] rsp_data
);

  logic [lsu_mem_pkg::DATA_SIZE-1:0]     ext;
  logic [lsu_mem_pkg::BYTE_SIZE-1:0]     lo_byte;
  logic [2*lsu_mem_pkg::BYTE_SIZE-1:0]   lo_half;

  assign lo_byte = dat_r[lsu_mem_pkg::BYTE_SIZE-1:0];
  assign lo_half = dat_r[2*lsu_mem_pkg::BYTE_SIZE-1:0];

  // Stores come back zero-extended like the unsigned loads
  always_comb begin
    case (op)
      lsu_mem_pkg::OP_LB:
        ext = {{(lsu_mem_pkg::DATA_SIZE - lsu_mem_pkg::BYTE_SIZE){lo_byte[$high(lo_byte)]}},
               lo_byte};
      lsu_mem_pkg::OP_LH:
        ext = {{(lsu_mem_pkg::DATA_SIZE - 2*lsu_mem_pkg::BYTE_SIZE){lo_half[$high(lo_half)]}},
               lo_half};
      lsu_mem_pkg::OP_LBU, lsu_mem_pkg::OP_SB:
        ext = {{(lsu_mem_pkg::DATA_SIZE - lsu_mem_pkg::BYTE_SIZE){1'b0}}, lo_byte};
      lsu_mem_pkg::OP_LHU, lsu_mem_pkg::OP_SH:
        ext = {{(lsu_mem_pkg::DATA_SIZE - 2*lsu_mem_pkg::BYTE_SIZE){1'b0}}, lo_half};
      default:
        ext = dat_r;
    endcase
  end

  // One response per acknowledge
  always_ff @(posedge CLK_I or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= ack;
    end
  end

  always_ff @(posedge CLK_I) begin
    if (ack) begin
      rsp_data <= ext;
    end
  end

endmodule

`default_nettype wire

// File: lsu_mem_top.sv
// Top level of the load/store data memory, command in and response out on plain ports
`default_nettype none

module lsu_mem_top (
  input  logic                              CLK_I,
  input  logic                              arst_n,
  input  logic                              cmd_valid,
  input  lsu_mem_pkg::mem_op_e              cmd_op,
  input  logic [lsu_mem_pkg::DATA_SIZE-1:0] cmd_addr,
  input  logic [lsu_mem_pkg::DATA_SIZE-1:0] cmd_wdata,
  output logic                              cmd_ready,
  output logic                              rsp_valid,
  output logic [lsu_mem_pkg::DATA_SIZE-1:0] rsp_data
);

  // Opcode held by the request stage for the response stage
  lsu_mem_pkg::mem_op_e op_q;

  wb_if bus ();

  mem_request i_mem_request (
    .CLK_I     (CLK_I),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_addr  (cmd_addr),
    .cmd_wdata (cmd_wdata),
    .cmd_ready (cmd_ready),
    .op_q      (op_q),
    .bus       (bus.master)
  );

  wb_byte_ram i_wb_byte_ram (
    .CLK_I  (CLK_I),
    .arst_n (arst_n),
    .bus    (bus.slave)
  );

  load_extend i_load_extend (
    .CLK_I     (CLK_I),
    .arst_n    (arst_n),
    .ack       (bus.ack),
    .dat_r     (bus.dat_r),
    .op        (op_q),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data)
  );

endmodule

`default_nettype wire

// File: lsu_mem_assertions.sv
// Concurrent bus checks on the byte-lane RAM, attached to it by a bind in the testbench
`default_nettype none

module lsu_mem_assertions (
  input logic CLK_I,
  input logic arst_n,
  input logic cyc,
  input logic stb,
  input logic ack
);

  localparam int BUSY = lsu_mem_pkg::BUSY_CYCLES;

  int unsigned fail_count = 0;

  // Acknowledge is a single-cycle pulse
  ack_one_cycle: assert property (@(posedge CLK_I) disable iff (!arst_n) ack |=> !ack)
    else begin
      $error("ack stayed high for a second cycle");
      fail_count++;
    end

  // A new strobe is answered after the busy delay
  ack_after_busy: assert property (@(posedge CLK_I) disable iff (!arst_n)
    $rose(stb) |-> ##BUSY ack)
    else begin
      $error("ack did not follow the strobe after the busy delay");
      fail_count++;
    end

  // Master holds the cycle until it sees ack
  stb_until_ack: assert property (@(posedge CLK_I) disable iff (!arst_n)
    (cyc && stb && !ack) |=> (cyc && stb))
    else begin
      $error("stb dropped before ack");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: lsu_mem_checker.sv
// Testbench checker that models memory bytes and compares every response and its latency
`default_nettype none

module lsu_mem_checker (
  input  logic                              CLK_I,
  input  logic                              arst_n,
  input  logic                              cmd_valid,
  input  logic                              cmd_ready,
  input  lsu_mem_pkg::mem_op_e              cmd_op,
  input  logic [lsu_mem_pkg::DATA_SIZE-1:0] cmd_addr,
  input  logic [lsu_mem_pkg::DATA_SIZE-1:0] cmd_wdata,
  input  logic                              rsp_valid,
  input  logic [lsu_mem_pkg::DATA_SIZE-1:0] rsp_data,
  output int unsigned                       error_count,
  output int unsigned                       rsp_count
);

  localparam int DATA = lsu_mem_pkg::DATA_SIZE;
  localparam int BW = lsu_mem_pkg::BYTE_SIZE;
  localparam int MEM_BYTES = 2 ** lsu_mem_pkg::ADDR_SIZE;
  // Edges from acceptance to the edge after which rsp_valid is high
  localparam int LATENCY = lsu_mem_pkg::BUSY_CYCLES + 1;

  logic [BW-1:0]        model [MEM_BYTES];
  logic                 known [MEM_BYTES];
  logic                 pending = 1'b0;
  logic                 exp_known;
  logic [DATA-1:0]      exp_data;
  lsu_mem_pkg::mem_op_e exp_op;
  int                   edge_cnt = 0;
  int                   accept_edge = 0;
  int unsigned          err_cnt = 0;
  int unsigned          rsp_cnt = 0;

  assign error_count = err_cnt;
  assign rsp_count   = rsp_cnt;

  function automatic int op_bytes(lsu_mem_pkg::mem_op_e op);
    case (op)
      lsu_mem_pkg::OP_LB, lsu_mem_pkg::OP_LBU, lsu_mem_pkg::OP_SB: return 1;
      lsu_mem_pkg::OP_LH, lsu_mem_pkg::OP_LHU, lsu_mem_pkg::OP_SH: return 2;
      default: return 4;
    endcase
  endfunction

  always @(posedge CLK_I) begin
    int nbytes;
    int idx;
    int age;
    edge_cnt++;
    age = edge_cnt - accept_edge - 1;
    if (!arst_n) begin
      pending = 1'b0;
      for (int i = 0; i < MEM_BYTES; i++) begin
        known[i] = 1'b0;
      end
    end else begin
      if (rsp_valid && !pending) begin
        $display("ERROR at time %0t: response with no command outstanding", $time);
        err_cnt++;
      end else if (rsp_valid) begin
        if (age != LATENCY) begin
          $display("ERROR at time %0t: %s response after %0d edges, expected %0d",
                   $time, exp_op.name(), age, LATENCY);
          err_cnt++;
        end
        if (exp_known && rsp_data !== exp_data) begin
          $display("ERROR at time %0t: %s data 0x%08h, expected 0x%08h",
                   $time, exp_op.name(), rsp_data, exp_data);
          err_cnt++;
        end
        // Ready returns on the same edge that raises the response
        if (!cmd_ready) begin
          $display("ERROR at time %0t: cmd_ready low with the %s response",
                   $time, exp_op.name());
          err_cnt++;
        end
        rsp_cnt++;
        pending = 1'b0;
      end else if (pending && age >= LATENCY) begin
        $display("ERROR at time %0t: no response to %s", $time, exp_op.name());
        err_cnt++;
        pending = 1'b0;
      end
      if (pending && cmd_ready) begin
        $display("ERROR at time %0t: cmd_ready high while a command is open", $time);
        err_cnt++;
      end
      if (cmd_valid && cmd_ready) begin
        nbytes = op_bytes(cmd_op);
        exp_data = '0;
        exp_known = 1'b1;
        exp_op = cmd_op;
        // Lane i reads the old byte at (addr + i), then a store replaces it
        for (int i = 0; i < nbytes; i++) begin
          idx = (int'(cmd_addr[lsu_mem_pkg::ADDR_SIZE-1:0]) + i) % MEM_BYTES;
          exp_data[i*BW +: BW] = model[idx];
          exp_known = exp_known & known[idx];
          if (cmd_op inside {lsu_mem_pkg::OP_SB, lsu_mem_pkg::OP_SH, lsu_mem_pkg::OP_SW}) begin
            model[idx] = cmd_wdata[i*BW +: BW];
            known[idx] = 1'b1;
          end
        end
        if (cmd_op == lsu_mem_pkg::OP_LB) begin
          exp_data = DATA'($signed(exp_data[BW-1:0]));
        end
        if (cmd_op == lsu_mem_pkg::OP_LH) begin
          exp_data = DATA'($signed(exp_data[2*BW-1:0]));
        end
        pending = 1'b1;
        accept_edge = edge_cnt;
      end
    end
  end

endmodule

`default_nettype wire

// File: lsu_mem_tb.sv
// Testbench top that drives directed and random load/store commands and prints the result
`default_nettype none

module lsu_mem_tb;

  localparam int DATA = lsu_mem_pkg::DATA_SIZE;
  localparam int MEM_BYTES = 2 ** lsu_mem_pkg::ADDR_SIZE;
  localparam int WAIT_LIMIT = 20;

  logic                 CLK_I;
  logic                 arst_n;
  logic                 cmd_valid;
  logic                 cmd_ready;
  logic                 rsp_valid;
  lsu_mem_pkg::mem_op_e cmd_op;
  logic [DATA-1:0]      cmd_addr;
  logic [DATA-1:0]      cmd_wdata;
  logic [DATA-1:0]      rsp_data;
  logic [31:0]          lfsr;
  int unsigned          tb_errors;
  int unsigned          cmd_count;
  int unsigned          chk_errors;
  int unsigned          chk_rsp;

  lsu_mem_top i_lsu_mem_top (
    .CLK_I(CLK_I), .arst_n(arst_n), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
    .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata), .cmd_ready(cmd_ready),
    .rsp_valid(rsp_valid), .rsp_data(rsp_data)
  );

  lsu_mem_checker i_lsu_mem_checker (
    .CLK_I(CLK_I), .arst_n(arst_n), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
    .cmd_op(cmd_op), .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata), .rsp_valid(rsp_valid),
    .rsp_data(rsp_data), .error_count(chk_errors), .rsp_count(chk_rsp)
  );

  bind wb_byte_ram lsu_mem_assertions i_lsu_mem_assertions (
    .CLK_I(CLK_I), .arst_n(arst_n), .cyc(bus.cyc), .stb(bus.stb), .ack(bus.ack)
  );

  initial begin
    CLK_I = 1'b0;
    forever #20 CLK_I = ~CLK_I;
  end

  // Galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  function automatic int unsigned total_errors();
    return tb_errors + chk_errors + i_lsu_mem_top.i_wb_byte_ram.i_lsu_mem_assertions.fail_count;
  endfunction

  task automatic wait_ready();
    int n;
    n = 0;
    while (!cmd_ready && n < WAIT_LIMIT) begin
      @(negedge CLK_I);
      n++;
    end
    if (!cmd_ready) begin
      $display("Timed out waiting for cmd_ready at time %0t", $time);
      tb_errors++;
    end
  endtask

  // One command and its response; with jam set, stores to jam_addr are pushed while busy
  task automatic run_cmd(input lsu_mem_pkg::mem_op_e op, input logic [DATA-1:0] addr,
                         input logic [DATA-1:0] wdata, input logic jam,
                         input logic [DATA-1:0] jam_addr);
    int n;
    wait_ready();
    cmd_valid = 1'b1;
    cmd_op = op;
    cmd_addr = addr;
    cmd_wdata = wdata;
    cmd_count++;
    @(negedge CLK_I);
    cmd_valid = 1'b0;
    n = 0;
    while (!rsp_valid && n < WAIT_LIMIT) begin
      if (jam) begin
        cmd_valid = 1'b1;
        cmd_op = lsu_mem_pkg::OP_SW;
        cmd_addr = jam_addr;
        cmd_wdata = rand_bits(DATA);
      end
      @(negedge CLK_I);
      cmd_valid = 1'b0;
      n++;
    end
    if (!rsp_valid) begin
      $display("Timed out waiting for rsp_valid after %s at time %0t", op.name(), $time);
      tb_errors++;
    end
  endtask

  task automatic print_result(input string name, input int unsigned c0, input int unsigned e0);
    // Let the checker see the last response first
    @(negedge CLK_I);
    $display("%s: %0d commands, %0d errors", name, cmd_count - c0, total_errors() - e0);
  endtask

  initial begin
    int unsigned          c0;
    int unsigned          e0;
    logic [31:0]          r;
    logic [DATA-1:0]      a;
    logic [DATA-1:0]      d;
    lsu_mem_pkg::mem_op_e op;
    lfsr = 32'hc839;
    tb_errors = 0;
    cmd_count = 0;
    arst_n = 1'b0;
    cmd_valid = 1'b0;
    cmd_op = lsu_mem_pkg::OP_LB;
    cmd_addr = '0;
    cmd_wdata = '0;
    repeat (3) @(posedge CLK_I);
    @(negedge CLK_I);
    arst_n = 1'b1;
    @(negedge CLK_I);

    c0 = cmd_count;
    e0 = total_errors();
    if (cmd_ready !== 1'b1 || rsp_valid !== 1'b0) begin
      $display("ERROR at time %0t: cmd_ready=%b rsp_valid=%b after reset",
               $time, cmd_ready, rsp_valid);
      tb_errors++;
    end
    print_result("reset_state", c0, e0);

    c0 = cmd_count;
    e0 = total_errors();
    for (int i = 0; i < MEM_BYTES; i += 4) begin
      run_cmd(lsu_mem_pkg::OP_SW, DATA'(i), rand_bits(DATA), 1'b0, '0);
    end
    for (int i = 0; i < MEM_BYTES; i += 4) begin
      run_cmd(lsu_mem_pkg::OP_LW, DATA'(i), '0, 1'b0, '0);
    end
    print_result("fill_readback", c0, e0);

    c0 = cmd_count;
    e0 = total_errors();
    repeat (200) begin
      r = rand_bits(3);
      op = lsu_mem_pkg::mem_op_e'(r[2:0]);
      a = rand_bits(DATA);
      d = rand_bits(DATA);
      run_cmd(op, a, d, 1'b0, '0);
    end
    print_result("random_traffic", c0, e0);

    // Accesses that run off the top of memory and wrap to byte 0
    c0 = cmd_count;
    e0 = total_errors();
    for (int i = MEM_BYTES - 3; i < MEM_BYTES; i++) begin
      run_cmd(lsu_mem_pkg::OP_SW, DATA'(i), rand_bits(DATA), 1'b0, '0);
      run_cmd(lsu_mem_pkg::OP_LW, DATA'(i), '0, 1'b0, '0);
      run_cmd(lsu_mem_pkg::OP_LW, DATA'(MEM_BYTES - 4), '0, 1'b0, '0);
      run_cmd(lsu_mem_pkg::OP_LW, '0, '0, 1'b0, '0);
      run_cmd(lsu_mem_pkg::OP_SH, DATA'(i), rand_bits(DATA), 1'b0, '0);
      run_cmd(lsu_mem_pkg::OP_LHU, DATA'(i), '0, 1'b0, '0);
      run_cmd(lsu_mem_pkg::OP_LH, DATA'(i), '0, 1'b0, '0);
    end
    print_result("unaligned_wrap", c0, e0);

    // Stores strobed while busy must leave their target untouched
    c0 = cmd_count;
    e0 = total_errors();
    repeat (8) begin
      r = rand_bits(3);
      op = lsu_mem_pkg::mem_op_e'(r[2:0]);
      a = rand_bits(lsu_mem_pkg::ADDR_SIZE);
      d = rand_bits(lsu_mem_pkg::ADDR_SIZE);
      run_cmd(op, a, rand_bits(DATA), 1'b1, d);
      run_cmd(lsu_mem_pkg::OP_LW, d, '0, 1'b0, '0);
    end
    print_result("back_pressure", c0, e0);

    if (chk_rsp != cmd_count) begin
      $display("Response count %0d does not match command count %0d", chk_rsp, cmd_count);
      tb_errors++;
    end
    $display("Summary: %0d commands, %0d responses checked, %0d errors",
             cmd_count, chk_rsp, total_errors());
    if (total_errors() == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: lsu_mem.f
lsu_mem_pkg.sv
wb_if.sv
mem_request.sv
wb_byte_ram.sv
load_extend.sv
lsu_mem_top.sv
lsu_mem_assertions.sv
lsu_mem_checker.sv
lsu_mem_tb.sv

// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert
TOP      ?= lsu_mem_tb
FILELIST ?= lsu_mem.f
OBJ_DIR  ?= obj_dir

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
